//--- verilog/fifo_params.svh
`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

// stream side width, one byte per push
`define FIFO_W_DATA_W 8

// host side width, one word per pop
`define FIFO_R_DATA_W 32

// byte address width, 64 bytes of storage
`define FIFO_ADDR_W 6

// bytes per read word
`define FIFO_RATIO 4

// host register map
`define AXIL_ADDR_W 4
`define REG_DATA 'h0
`define REG_STATUS 'h4
`define REG_CTRL 'h8

`endif

//--- verilog/fifo_pkg.sv
`default_nettype none

`include "fifo_params.svh"

package fifo_pkg;

   typedef logic [`FIFO_W_DATA_W-1:0] byte_t;
   typedef logic [`FIFO_R_DATA_W-1:0] word_t;
   // one bit wider than the address so 64 fits
   typedef logic [`FIFO_ADDR_W:0] level_t;
   typedef logic [`FIFO_ADDR_W-1:0] waddr_t;
   typedef logic [`FIFO_ADDR_W-$clog2(`FIFO_RATIO)-1:0] raddr_t;
   typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;

   typedef struct packed {
      logic  en;
      byte_t data;
   } fifo_wr_t;

   // one-hot lane enables select the byte inside the word
   typedef struct packed {
      logic [`FIFO_RATIO-1:0] en;
      raddr_t                 addr;
      byte_t                  data;
   } ram_wr_t;

   typedef struct packed {
      logic   en;
      raddr_t addr;
   } ram_rd_t;

   typedef struct packed {
      level_t level;
      logic   empty;
      logic   full;
   } fifo_stat_t;

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_FETCH,
      RD_RESP
   } axil_rd_state_e;

endpackage

`default_nettype wire

//--- verilog/byte_ingest.sv
`timescale 1ns/10ps
`default_nettype none

module byte_ingest (
   input  wire                  clk_i,
   input  wire                  rst_n_i,
   input  wire                  s_valid_i,
   input  fifo_pkg::byte_t      s_data_i,
   output logic                 s_ready_o,
   input  fifo_pkg::fifo_stat_t stat_i,
   output fifo_pkg::fifo_wr_t   wr_o
);

   import fifo_pkg::*;

   logic  skid_vld_q;
   byte_t skid_data_q;
   logic  live_q;
   logic  drain;
   logic  accept;

   // skid byte moves on whenever the fifo has room
   assign drain = skid_vld_q & ~stat_i.full;

   // free slot, or the held byte leaves this cycle
   assign s_ready_o = live_q & (~skid_vld_q | drain);
   assign accept    = s_valid_i & s_ready_o;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         live_q     <= 1'b0;
         skid_vld_q <= 1'b0;
      end else begin
         live_q <= 1'b1;
         if (accept) begin
            skid_vld_q <= 1'b1;
         end else if (drain) begin
            skid_vld_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         skid_data_q <= s_data_i;
      end
   end

   assign wr_o.en   = drain;
   assign wr_o.data = skid_data_q;

endmodule

`default_nettype wire

//--- verilog/fifo_sync_asym.sv
`timescale 1ns/10ps
`default_nettype none

`include "fifo_params.svh"

module fifo_sync_asym (
   input  wire                  clk_i,
   input  wire                  rst_n_i,
   input  wire                  flush_i,
   input  fifo_pkg::fifo_wr_t   wr_i,
   input  wire                  pop_i,
   output fifo_pkg::fifo_stat_t stat_o,
   output fifo_pkg::ram_wr_t    ram_wr_o,
   output fifo_pkg::ram_rd_t    ram_rd_o
);

   import fifo_pkg::*;

   localparam int LANE_W = $clog2(`FIFO_RATIO);
   localparam level_t FIFO_SIZE = level_t'(1 << `FIFO_ADDR_W);
   localparam level_t R_INCR = level_t'(`FIFO_RATIO);

   waddr_t wptr_q;
   raddr_t rptr_q;
   level_t level_q;
   level_t level_nxt;
   logic   empty_q;
   logic   full_q;
   logic   push;
   logic   pop;

   // ingest and host port only request when the flags allow it
   assign push = wr_i.en;
   assign pop  = pop_i;

   always_comb begin
      level_nxt = level_q;
      if (flush_i) begin
         level_nxt = '0;
      end else begin
         if (push) begin
            level_nxt = level_nxt + level_t'(1);
         end
         if (pop) begin
            level_nxt = level_nxt - R_INCR;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wptr_q  <= '0;
         rptr_q  <= '0;
         level_q <= '0;
         empty_q <= 1'b1;
         full_q  <= 1'b0;
      end else begin
         level_q <= level_nxt;
         // flags come from the next level, so they line up with it
         empty_q <= (level_nxt < R_INCR);
         full_q  <= (level_nxt > (FIFO_SIZE - level_t'(1)));
         if (flush_i) begin
            wptr_q <= '0;
            rptr_q <= '0;
         end else begin
            if (push) begin
               wptr_q <= wptr_q + waddr_t'(1);
            end
            if (pop) begin
               rptr_q <= rptr_q + raddr_t'(1);
            end
         end
      end
   end

   assign stat_o.level = level_q;
   assign stat_o.empty = empty_q;
   assign stat_o.full  = full_q;

   // low pointer bits pick the lane, little-endian packing
   always_comb begin
      ram_wr_o.en = '0;
      if (push && !flush_i) begin
         ram_wr_o.en[wptr_q[LANE_W-1:0]] = 1'b1;
      end
   end

   assign ram_wr_o.addr = wptr_q[`FIFO_ADDR_W-1:LANE_W];
   assign ram_wr_o.data = wr_i.data;

   assign ram_rd_o.en   = pop;
   assign ram_rd_o.addr = rptr_q;

   // ingest must hold back while the registered full flag is set
   a_no_push_full: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      wr_i.en |-> !full_q
   );

   // host port must not pop a partial word
   a_no_pop_empty: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      pop_i |-> !empty_q
   );

endmodule

`default_nettype wire

//--- verilog/ram_2p_asym.sv
`timescale 1ns/10ps
`default_nettype none

`include "fifo_params.svh"

module ram_2p_asym (
   input  wire                clk_i,
   input  fifo_pkg::ram_wr_t  wr_i,
   input  fifo_pkg::ram_rd_t  rd_i,
   output fifo_pkg::word_t    rd_data_o
);

   import fifo_pkg::*;

   localparam int DEPTH = 1 << $bits(raddr_t);
   localparam int LANE_BITS = `FIFO_W_DATA_W;

   word_t mem_q [DEPTH];
   word_t rd_data_q;

   // only the enabled byte lanes change
   always_ff @(posedge clk_i) begin
      for (int l = 0; l < `FIFO_RATIO; l++) begin
         if (wr_i.en[l]) begin
            mem_q[wr_i.addr][l*LANE_BITS +: LANE_BITS] <= wr_i.data;
         end
      end
   end

   // whole word read, held between reads
   always_ff @(posedge clk_i) begin
      if (rd_i.en) begin
         rd_data_q <= mem_q[rd_i.addr];
      end
   end

   assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

//--- verilog/axil_fifo_port.sv
`timescale 1ns/10ps
`default_nettype none

`include "fifo_params.svh"

module axil_fifo_port (
   input  wire                     clk_i,
   input  wire                     rst_n_i,
   input  fifo_pkg::axil_addr_t    s_axil_awaddr_i,
   input  wire                     s_axil_awvalid_i,
   output logic                    s_axil_awready_o,
   input  fifo_pkg::word_t         s_axil_wdata_i,
   input  wire                     s_axil_wvalid_i,
   output logic                    s_axil_wready_o,
   output logic [1:0]              s_axil_bresp_o,
   output logic                    s_axil_bvalid_o,
   input  wire                     s_axil_bready_i,
   input  fifo_pkg::axil_addr_t    s_axil_araddr_i,
   input  wire                     s_axil_arvalid_i,
   output logic                    s_axil_arready_o,
   output fifo_pkg::word_t         s_axil_rdata_o,
   output logic [1:0]              s_axil_rresp_o,
   output logic                    s_axil_rvalid_o,
   input  wire                     s_axil_rready_i,
   input  fifo_pkg::fifo_stat_t    stat_i,
   input  fifo_pkg::word_t         rd_data_i,
   output logic                    pop_o,
   output logic                    flush_o
);

   import fifo_pkg::*;

   localparam logic [1:0] RESP_OKAY = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;
   localparam axil_addr_t ADDR_DATA = axil_addr_t'(`REG_DATA);
   localparam axil_addr_t ADDR_STATUS = axil_addr_t'(`REG_STATUS);
   localparam axil_addr_t ADDR_CTRL = axil_addr_t'(`REG_CTRL);
   localparam int STAT_EMPTY_BIT = 8;
   localparam int STAT_FULL_BIT = 9;

   axil_rd_state_e rd_state_q;
   logic           popped_q;
   logic           live_q;
   logic           ar_fire;
   logic           wr_fire;
   logic           bvalid_q;
   logic [1:0]     bresp_q;
   logic [1:0]     rresp_q;
   word_t          rdata_q;
   word_t          status_word;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         live_q <= 1'b0;
      end else begin
         live_q <= 1'b1;
      end
   end

   always_comb begin
      status_word = '0;
      status_word[$bits(level_t)-1:0] = stat_i.level;
      status_word[STAT_EMPTY_BIT] = stat_i.empty;
      status_word[STAT_FULL_BIT] = stat_i.full;
   end

   // read channel
   assign s_axil_arready_o = live_q & (rd_state_q == RD_IDLE);
   assign ar_fire = s_axil_arvalid_i & s_axil_arready_o;

   // first fetch cycle pops, second one takes the ram word
   assign pop_o = (rd_state_q == RD_FETCH) & ~popped_q & ~stat_i.empty;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rd_state_q <= RD_IDLE;
         popped_q   <= 1'b0;
      end else begin
         case (rd_state_q)
            RD_IDLE: begin
               if (ar_fire) begin
                  if (s_axil_araddr_i == ADDR_DATA && !stat_i.empty) begin
                     rd_state_q <= RD_FETCH;
                  end else begin
                     rd_state_q <= RD_RESP;
                  end
               end
            end
            RD_FETCH: begin
               if (popped_q) begin
                  popped_q   <= 1'b0;
                  rd_state_q <= RD_RESP;
               end else if (stat_i.empty) begin
                  // flushed under us, answer as an empty read
                  rd_state_q <= RD_RESP;
               end else begin
                  popped_q <= 1'b1;
               end
            end
            RD_RESP: begin
               if (s_axil_rready_i) begin
                  rd_state_q <= RD_IDLE;
               end
            end
            default: begin
               rd_state_q <= RD_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (ar_fire) begin
         if (s_axil_araddr_i == ADDR_STATUS) begin
            rdata_q <= status_word;
            rresp_q <= RESP_OKAY;
         end else begin
            rdata_q <= '0;
            rresp_q <= RESP_SLVERR;
         end
      end else if (rd_state_q == RD_FETCH && popped_q) begin
         rdata_q <= rd_data_i;
         rresp_q <= RESP_OKAY;
      end
   end

   assign s_axil_rvalid_o = (rd_state_q == RD_RESP);
   assign s_axil_rdata_o  = rdata_q;
   assign s_axil_rresp_o  = rresp_q;

   // write channel, aw and w taken in the same cycle
   assign s_axil_awready_o = live_q & ~bvalid_q & s_axil_awvalid_i & s_axil_wvalid_i;
   assign s_axil_wready_o  = s_axil_awready_o;
   assign wr_fire = s_axil_awready_o;

   assign flush_o = wr_fire & (s_axil_awaddr_i == ADDR_CTRL) & s_axil_wdata_i[0];

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         bvalid_q <= 1'b0;
      end else if (wr_fire) begin
         bvalid_q <= 1'b1;
      end else if (s_axil_bready_i) begin
         bvalid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_fire) begin
         bresp_q <= (s_axil_awaddr_i == ADDR_CTRL) ? RESP_OKAY : RESP_SLVERR;
      end
   end

   assign s_axil_bvalid_o = bvalid_q;
   assign s_axil_bresp_o  = bresp_q;

   a_r_hold: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      s_axil_rvalid_o && !s_axil_rready_i |=>
         s_axil_rvalid_o && $stable(s_axil_rdata_o) && $stable(s_axil_rresp_o)
   );

   a_b_hold: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      s_axil_bvalid_o && !s_axil_bready_i |=>
         s_axil_bvalid_o && $stable(s_axil_bresp_o)
   );

endmodule

`default_nettype wire

//--- verilog/fifo_axil_top.sv
`timescale 1ns/10ps
`default_nettype none

module fifo_axil_top (
   input  wire                  clk_i,
   input  wire                  rst_n_i,
   input  wire                  s_valid_i,
   input  fifo_pkg::byte_t      s_data_i,
   output logic                 s_ready_o,
   input  fifo_pkg::axil_addr_t s_axil_awaddr_i,
   input  wire                  s_axil_awvalid_i,
   output logic                 s_axil_awready_o,
   input  fifo_pkg::word_t      s_axil_wdata_i,
   input  wire                  s_axil_wvalid_i,
   output logic                 s_axil_wready_o,
   output logic [1:0]           s_axil_bresp_o,
   output logic                 s_axil_bvalid_o,
   input  wire                  s_axil_bready_i,
   input  fifo_pkg::axil_addr_t s_axil_araddr_i,
   input  wire                  s_axil_arvalid_i,
   output logic                 s_axil_arready_o,
   output fifo_pkg::word_t      s_axil_rdata_o,
   output logic [1:0]           s_axil_rresp_o,
   output logic                 s_axil_rvalid_o,
   input  wire                  s_axil_rready_i
);

   import fifo_pkg::*;

   fifo_wr_t   fifo_wr;
   fifo_stat_t fifo_stat;
   ram_wr_t    ram_wr;
   ram_rd_t    ram_rd;
   word_t      ram_rd_data;
   logic       fifo_pop;
   logic       fifo_flush;

   byte_ingest u_ingest (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .s_valid_i (s_valid_i),
      .s_data_i  (s_data_i),
      .s_ready_o (s_ready_o),
      .stat_i    (fifo_stat),
      .wr_o      (fifo_wr)
   );

   fifo_sync_asym u_fifo (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .flush_i  (fifo_flush),
      .wr_i     (fifo_wr),
      .pop_i    (fifo_pop),
      .stat_o   (fifo_stat),
      .ram_wr_o (ram_wr),
      .ram_rd_o (ram_rd)
   );

   ram_2p_asym u_ram (
      .clk_i     (clk_i),
      .wr_i      (ram_wr),
      .rd_i      (ram_rd),
      .rd_data_o (ram_rd_data)
   );

   axil_fifo_port u_axil (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .s_axil_awaddr_i  (s_axil_awaddr_i),
      .s_axil_awvalid_i (s_axil_awvalid_i),
      .s_axil_awready_o (s_axil_awready_o),
      .s_axil_wdata_i   (s_axil_wdata_i),
      .s_axil_wvalid_i  (s_axil_wvalid_i),
      .s_axil_wready_o  (s_axil_wready_o),
      .s_axil_bresp_o   (s_axil_bresp_o),
      .s_axil_bvalid_o  (s_axil_bvalid_o),
      .s_axil_bready_i  (s_axil_bready_i),
      .s_axil_araddr_i  (s_axil_araddr_i),
      .s_axil_arvalid_i (s_axil_arvalid_i),
      .s_axil_arready_o (s_axil_arready_o),
      .s_axil_rdata_o   (s_axil_rdata_o),
      .s_axil_rresp_o   (s_axil_rresp_o),
      .s_axil_rvalid_o  (s_axil_rvalid_o),
      .s_axil_rready_i  (s_axil_rready_i),
      .stat_i           (fifo_stat),
      .rd_data_i        (ram_rd_data),
      .pop_o            (fifo_pop),
      .flush_o          (fifo_flush)
   );

endmodule

`default_nettype wire

//--- bench/tb_fifo_axil.sv
`timescale 1ns/10ps
`default_nettype none

`include "fifo_params.svh"

module tb_fifo_axil;

   import fifo_pkg::*;

   // stream bytes and bus transfers in the sequence below
   localparam int N_BYTES = 12 + 6 + 70 + 5 + 30;
   localparam int N_BUS = 46;
   localparam int WATCHDOG_CYCLES = (N_BYTES + N_BUS) * 40;
   localparam int STALL_LIMIT = 16;
   localparam int CAPACITY = 1 << `FIFO_ADDR_W;
   localparam logic [1:0] OKAY = 2'b00;
   localparam logic [1:0] SLVERR = 2'b10;

   logic       clk;
   logic       rst_n;
   logic       s_valid;
   byte_t      s_data;
   logic       s_ready;
   axil_addr_t awaddr;
   logic       awvalid;
   logic       awready;
   word_t      wdata;
   logic       wvalid;
   logic       wready;
   logic [1:0] bresp;
   logic       bvalid;
   logic       bready;
   axil_addr_t araddr;
   logic       arvalid;
   logic       arready;
   word_t      rdata;
   logic [1:0] rresp;
   logic       rvalid;
   logic       rready;

   int    errors = 0;
   int    seed = 2;
   byte_t model_q[$];

   fifo_axil_top u_fifo_axil_top (
      .clk_i            (clk),
      .rst_n_i          (rst_n),
      .s_valid_i        (s_valid),
      .s_data_i         (s_data),
      .s_ready_o        (s_ready),
      .s_axil_awaddr_i  (awaddr),
      .s_axil_awvalid_i (awvalid),
      .s_axil_awready_o (awready),
      .s_axil_wdata_i   (wdata),
      .s_axil_wvalid_i  (wvalid),
      .s_axil_wready_o  (wready),
      .s_axil_bresp_o   (bresp),
      .s_axil_bvalid_o  (bvalid),
      .s_axil_bready_i  (bready),
      .s_axil_araddr_i  (araddr),
      .s_axil_arvalid_i (arvalid),
      .s_axil_arready_o (arready),
      .s_axil_rdata_o   (rdata),
      .s_axil_rresp_o   (rresp),
      .s_axil_rvalid_o  (rvalid),
      .s_axil_rready_i  (rready)
   );

   initial begin
      clk = 1'b0;
   end

   always #4 clk = ~clk;

   // reference model takes every accepted byte
   always @(posedge clk) begin
      if (rst_n && s_valid && s_ready) begin
         model_q.push_back(s_data);
      end
   end

   a_reset_quiet: assert property (
      @(posedge clk) $rose(rst_n) |->
         !(s_ready || arready || awready || wready || rvalid || bvalid)
   ) else begin
      errors++;
      $display("Error: a handshake output was high in the first cycle after reset");
   end

   a_r_stable: assert property (
      @(posedge clk) disable iff (!rst_n)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
   ) else begin
      errors++;
      $display("Error: rdata %h rresp %h changed or dropped before RREADY", rdata, rresp);
   end

   a_b_stable: assert property (
      @(posedge clk) disable iff (!rst_n)
      bvalid && !bready |=> bvalid && $stable(bresp)
   ) else begin
      errors++;
      $display("Error: bresp %h changed or BVALID dropped before BREADY", bresp);
   end

   a_no_ar_while_r: assert property (
      @(posedge clk) disable iff (!rst_n)
      rvalid |-> !arready
   ) else begin
      errors++;
      $display("Error: ARREADY high while a read response was pending");
   end

   function automatic void check_value(string name, logic [31:0] got, logic [31:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("Error: %s got %h expected %h", name, got, exp);
      end
   endfunction

   // a full fifo holds 64 bytes and one more waits in the skid register
   function automatic int model_level();
      return (model_q.size() > CAPACITY) ? CAPACITY : model_q.size();
   endfunction

   task automatic axil_read(input axil_addr_t addr, input int stall, output word_t data,
                            output logic [1:0] resp, output int lat);
      int held;
      araddr  <= addr;
      arvalid <= 1'b1;
      @(posedge clk);
      while (!arready) begin
         @(posedge clk);
      end
      arvalid <= 1'b0;
      rready  <= (stall == 0);
      lat = 0;
      do begin
         @(posedge clk);
         lat++;
      end while (!rvalid);
      held = 0;
      while (!(rvalid && rready)) begin
         held++;
         if (held >= stall) begin
            rready <= 1'b1;
         end
         @(posedge clk);
      end
      data = rdata;
      resp = rresp;
      rready <= 1'b0;
   endtask

   task automatic axil_write(input axil_addr_t addr, input word_t data,
                             output logic [1:0] resp, output int lat);
      awaddr  <= addr;
      wdata   <= data;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      @(posedge clk);
      while (!(awready && wready)) begin
         @(posedge clk);
      end
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      lat = 0;
      do begin
         @(posedge clk);
         lat++;
      end while (!bvalid);
      // one cycle of back-pressure on B
      bready <= 1'b1;
      @(posedge clk);
      resp = bresp;
      bready <= 1'b0;
   endtask

   task automatic stream_bytes(input int n, output int sent);
      int wait_n;
      logic stuck;
      sent  = 0;
      stuck = 1'b0;
      while (sent < n && !stuck) begin
         s_valid <= 1'b1;
         s_data  <= byte_t'($random(seed));
         @(posedge clk);
         wait_n = 0;
         while (!s_ready && wait_n < STALL_LIMIT) begin
            wait_n++;
            @(posedge clk);
         end
         if (s_ready) begin
            sent++;
         end else begin
            stuck = 1'b1;
         end
      end
      s_valid <= 1'b0;
   endtask

   task automatic settle();
      repeat (4) @(posedge clk);
   endtask

   task automatic check_status();
      word_t      data;
      logic [1:0] resp;
      int         lat;
      int         lvl;
      lvl = model_level();
      axil_read(`REG_STATUS, 0, data, resp, lat);
      check_value("rresp", resp, OKAY);
      check_value("status.level", data[6:0], lvl);
      check_value("status.empty", data[8], lvl < `FIFO_RATIO);
      check_value("status.full", data[9], lvl == CAPACITY);
      check_value("STATUS rvalid latency", lat, 1);
   endtask

   // first byte of the stream lands in bits 7:0
   task automatic read_data(input int stall);
      word_t      data;
      word_t      exp;
      logic [1:0] resp;
      int         lat;
      logic       avail;
      avail = (model_level() >= `FIFO_RATIO);
      exp = '0;
      if (avail) begin
         for (int i = 0; i < `FIFO_RATIO; i++) begin
            exp[i*`FIFO_W_DATA_W +: `FIFO_W_DATA_W] = model_q[i];
         end
      end
      axil_read(`REG_DATA, stall, data, resp, lat);
      if (avail) begin
         repeat (`FIFO_RATIO) void'(model_q.pop_front());
      end
      check_value("rresp", resp, avail ? OKAY : SLVERR);
      check_value("rdata", data, exp);
      check_value("DATA rvalid latency", lat, avail ? 3 : 1);
   endtask

   task automatic read_unmapped(input axil_addr_t addr);
      word_t      data;
      logic [1:0] resp;
      int         lat;
      axil_read(addr, 0, data, resp, lat);
      check_value("rresp", resp, SLVERR);
      check_value("rdata", data, 32'h0);
   endtask

   task automatic write_reg(input axil_addr_t addr, input word_t data,
                            input logic [1:0] exp_resp);
      logic [1:0] resp;
      int         lat;
      axil_write(addr, data, resp, lat);
      if (addr == `REG_CTRL && data[0]) begin
         model_q.delete();
      end
      check_value("bresp", resp, exp_resp);
      check_value("BVALID latency", lat, 1);
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("run timed out after %0d cycles before the tests completed", WATCHDOG_CYCLES);
      $display("Finished with errors");
      $finish;
   end

   initial begin
      int sent;
      rst_n   = 1'b0;
      s_valid = 1'b0;
      s_data  = '0;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);

      // empty after reset and a refused DATA read
      check_status();
      read_data(0);
      check_status();

      // little-endian packing in arrival order
      stream_bytes(12, sent);
      settle();
      check_status();
      repeat (3) read_data(0);
      check_status();

      // partial word stays behind and reads as empty
      stream_bytes(6, sent);
      settle();
      check_status();
      read_data(0);
      check_status();
      read_data(0);
      check_status();

      // flush and unmapped accesses
      write_reg(`REG_CTRL, 32'h1, OKAY);
      check_status();
      read_unmapped(4'hC);
      write_reg(4'hC, 32'h1, SLVERR);

      // overfill until the skid register holds the last byte
      stream_bytes(70, sent);
      check_value("accepted bytes", sent, CAPACITY + 1);
      check_value("s_ready", s_ready, 1'b0);
      settle();
      check_status();
      repeat (2) read_data(0);
      settle();
      check_status();
      stream_bytes(5, sent);
      settle();
      while (model_level() >= `FIFO_RATIO) begin
         read_data(0);
      end
      check_status();

      // host back-pressure on R
      stream_bytes(30, sent);
      settle();
      repeat (8) read_data($random(seed) & 32'h7);
      check_status();

      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
+incdir+verilog
verilog/fifo_pkg.sv
verilog/byte_ingest.sv
verilog/fifo_sync_asym.sv
verilog/ram_2p_asym.sv
verilog/axil_fifo_port.sv
verilog/fifo_axil_top.sv
bench/tb_fifo_axil.sv
